// ==== arbiter_cache_pkg.sv ====
package arbiter_cache_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    localparam int NUM_CONSUMERS = 4;
    localparam int NUM_CHANNELS  = 2;
    localparam int ADDR_BITS     = 8;
    // chunk width, same on consumer and memory bus
    localparam int DATA_BITS     = 8;
    localparam int INDEX_BITS    = 4;
    localparam int TAG_BITS      = 3;
    // what is left of the address picks the chunk inside a line
    localparam int OFFSET_BITS   = ADDR_BITS - TAG_BITS - INDEX_BITS;
    localparam int NUM_CHUNKS    = 2 ** OFFSET_BITS;
    localparam int NUM_LINES     = 2 ** INDEX_BITS;
    localparam int LINE_BITS     = NUM_CHUNKS * DATA_BITS;
    localparam int CONS_ID_BITS  = $clog2(NUM_CONSUMERS);

    ////////////////////////////////////////
    // address and data types
    ////////////////////////////////////////

    typedef logic [TAG_BITS-1:0]     tag_t;
    typedef logic [INDEX_BITS-1:0]   index_t;
    typedef logic [OFFSET_BITS-1:0]  offset_t;
    typedef logic [CONS_ID_BITS-1:0] cons_id_t;
    typedef logic [DATA_BITS-1:0]    chunk_t;
    // chunk 0 sits in the low bits
    typedef logic [LINE_BITS-1:0]    line_data_t;

    // address layout, tag on top and offset at the bottom
    typedef struct packed {
        tag_t    tag;
        index_t  index;
        offset_t offset;
    } addr_t;

    typedef struct packed {
        logic       valid;
        tag_t       tag;
        line_data_t data;
    } cache_line_t;

    ////////////////////////////////////////
    // bus and internal payloads
    ////////////////////////////////////////

    // consumer side, valid and ready are levels
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } cons_req_t;

    typedef struct packed {
        logic   ready;
        chunk_t data;
    } cons_rsp_t;

    // memory side, ready is a one cycle pulse
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic   ready;
        chunk_t data;
    } mem_rsp_t;

    typedef struct packed {
        logic     start;
        cons_id_t cons_id;
        index_t   index;
        tag_t     tag;
    } fill_req_t;

    typedef struct packed {
        logic       done;
        cons_id_t   cons_id;
        index_t     index;
        tag_t       tag;
        line_data_t data;
    } fill_result_t;

endpackage

// ==== line_store.sv ====
`timescale 1ns/1ps

module line_store
    import arbiter_cache_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  addr_t        [NUM_CONSUMERS-1:0]  lookup_addr_i,
    input  fill_result_t [NUM_CHANNELS-1:0]   fill_i,
    output logic         [NUM_CONSUMERS-1:0]  hit_o,
    output chunk_t       [NUM_CONSUMERS-1:0]  rdata_o
);

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    // one valid flag per line
    logic [NUM_LINES-1:0] valid_q;
    tag_t                 tag_q  [NUM_LINES];
    line_data_t           data_q [NUM_LINES];

    ////////////////////////////////////////
    // lookup, one port per consumer
    ////////////////////////////////////////

    for (genvar c = 0; c < NUM_CONSUMERS; c++) begin : g_lookup
        cache_line_t entry;

        // gather the indexed line into one entry
        assign entry = '{
            valid: valid_q[lookup_addr_i[c].index],
            tag:   tag_q[lookup_addr_i[c].index],
            data:  data_q[lookup_addr_i[c].index]
        };

        // hit needs a valid line with a matching tag
        assign hit_o[c] = entry.valid && (entry.tag == lookup_addr_i[c].tag);

        // offset selects the chunk handed back
        assign rdata_o[c] = entry.data[lookup_addr_i[c].offset * DATA_BITS +: DATA_BITS];
    end

    ////////////////////////////////////////
    // install from finished fills
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_q <= '0;
        end else begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                if (fill_i[ch].done) begin
                    valid_q[fill_i[ch].index] <= 1'b1;
                end
            end
        end
    end

    // line locks keep concurrent fills on distinct lines
    always_ff @(posedge clk) begin
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (fill_i[ch].done) begin
                tag_q[fill_i[ch].index]  <= fill_i[ch].tag;
                data_q[fill_i[ch].index] <= fill_i[ch].data;
            end
        end
    end

endmodule

// ==== grant_picker.sv ====
`timescale 1ns/1ps

module grant_picker
    import arbiter_cache_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [NUM_CONSUMERS-1:0] eligible_i,
    output logic [NUM_CONSUMERS-1:0] grant_o
);

    // last consumer that got a grant, search starts one past it
    cons_id_t                 last_q;
    cons_id_t                 last_d;
    logic [NUM_CONSUMERS-1:0] grant_d;

    // round robin search over all consumers
    always_comb begin
        cons_id_t cand;

        grant_d = '0;
        last_d  = last_q;
        cand    = last_q;
        for (int k = 0; k < NUM_CONSUMERS; k++) begin
            // wraps on its own, consumer count is a power of two
            cand = CONS_ID_BITS'(32'(last_q) + 1 + k);
            // first hit wins
            if (eligible_i[cand] && (grant_d == '0)) begin
                grant_d[cand] = 1'b1;
                last_d        = cand;
            end
        end
    end

    // grant is registered, one cycle behind eligible
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            grant_o <= '0;
            // so the first search starts at consumer 0
            last_q  <= CONS_ID_BITS'(NUM_CONSUMERS - 1);
        end else begin
            grant_o <= grant_d;
            last_q  <= last_d;
        end
    end

endmodule

// ==== fill_channel.sv ====
`timescale 1ns/1ps

module fill_channel
    import arbiter_cache_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  fill_req_t    start_i,
    input  mem_rsp_t     mem_rsp_i,
    output mem_req_t     mem_req_o,
    output logic         busy_o,
    output fill_result_t result_o
);

    typedef enum logic [1:0] {
        FILL_IDLE,
        FILL_REQ,
        FILL_WAIT,
        FILL_DONE
    } fill_state_e;

    fill_state_e state_q;
    // chunk currently on the memory bus
    offset_t     chunk_q;
    // job details and assembled line
    fill_req_t   req_q;
    line_data_t  line_q;

    ////////////////////////////////////////
    // fill sequence
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= FILL_IDLE;
            chunk_q <= '0;
        end else begin
            case (state_q)
                FILL_IDLE: begin
                    // always begin with chunk 0 of the line
                    if (start_i.start) begin
                        chunk_q <= '0;
                        state_q <= FILL_WAIT;
                    end
                end
                // one idle bus cycle between chunks
                FILL_REQ: begin
                    state_q <= FILL_WAIT;
                end
                FILL_WAIT: begin
                    if (mem_rsp_i.ready) begin
                        if (chunk_q == OFFSET_BITS'(NUM_CHUNKS - 1)) begin
                            state_q <= FILL_DONE;
                        end else begin
                            chunk_q <= chunk_q + 1'b1;
                            state_q <= FILL_REQ;
                        end
                    end
                end
                // done pulse lasts this one cycle
                default: begin
                    state_q <= FILL_IDLE;
                end
            endcase
        end
    end

    // capture job and memory data
    always_ff @(posedge clk) begin
        if ((state_q == FILL_IDLE) && start_i.start) begin
            req_q <= start_i;
        end
        if ((state_q == FILL_WAIT) && mem_rsp_i.ready) begin
            line_q[chunk_q * DATA_BITS +: DATA_BITS] <= mem_rsp_i.data;
        end
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////

    // valid only while waiting, so it drops right after ready
    assign mem_req_o = '{
        valid: (state_q == FILL_WAIT),
        addr:  '{tag: req_q.tag, index: req_q.index, offset: chunk_q}
    };

    assign busy_o = (state_q != FILL_IDLE);

    assign result_o = '{
        done:    (state_q == FILL_DONE),
        cons_id: req_q.cons_id,
        index:   req_q.index,
        tag:     req_q.tag,
        data:    line_q
    };

endmodule

// ==== cache_control.sv ====
`timescale 1ns/1ps

module cache_control
    import arbiter_cache_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  cons_req_t    [NUM_CONSUMERS-1:0]  cons_req_i,
    input  logic         [NUM_CONSUMERS-1:0]  hit_i,
    input  chunk_t       [NUM_CONSUMERS-1:0]  rdata_i,
    input  logic         [NUM_CONSUMERS-1:0]  grant_i,
    input  logic         [NUM_CHANNELS-1:0]   chan_busy_i,
    input  fill_result_t [NUM_CHANNELS-1:0]   fill_done_i,
    output addr_t        [NUM_CONSUMERS-1:0]  lookup_addr_o,
    output logic         [NUM_CONSUMERS-1:0]  eligible_o,
    output fill_req_t    [NUM_CHANNELS-1:0]   start_o,
    output cons_rsp_t    [NUM_CONSUMERS-1:0]  cons_rsp_o
);

    typedef enum logic [1:0] {CONS_IDLE, CONS_MISS, CONS_RELAY} cons_state_e;

    cons_state_e              state_q [NUM_CONSUMERS];
    logic [NUM_CONSUMERS-1:0] ready_q;
    chunk_t                   data_q  [NUM_CONSUMERS];
    // consumer already owns a fill channel
    logic [NUM_CONSUMERS-1:0] assigned_q;
    // line being filled by some channel
    logic [NUM_LINES-1:0]     lock_q;

    logic [NUM_CHANNELS-1:0]  chan_pick;
    logic                     idle_any;
    cons_id_t                 gnt_id;
    addr_t                    gnt_addr;
    logic                     accept;

    ////////////////////////////////////////
    // channel steering
    ////////////////////////////////////////

    // isolate the lowest zero in the busy vector, all busy gives zero
    assign chan_pick = ~chan_busy_i & (chan_busy_i + 1'b1);
    assign idle_any  = |chan_pick;

    always_comb begin
        gnt_id = '0;
        for (int c = 0; c < NUM_CONSUMERS; c++) begin
            if (grant_i[c]) begin
                gnt_id = CONS_ID_BITS'(c);
            end
        end
    end

    assign gnt_addr = cons_req_i[gnt_id].addr;

    // grant is a cycle old, so check again that it is still good
    assign accept = (|grant_i) && (state_q[gnt_id] == CONS_MISS) && !hit_i[gnt_id]
                  && !assigned_q[gnt_id] && !lock_q[gnt_addr.index] && idle_any;

    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_start
        assign start_o[ch] = '{
            start:   accept && chan_pick[ch],
            cons_id: gnt_id,
            index:   gnt_addr.index,
            tag:     gnt_addr.tag
        };
    end

    for (genvar c = 0; c < NUM_CONSUMERS; c++) begin : g_cons
        assign lookup_addr_o[c] = cons_req_i[c].addr;
        // only ask for a grant while a channel could take it
        assign eligible_o[c] = (state_q[c] == CONS_MISS) && !hit_i[c] && !assigned_q[c]
                             && !lock_q[cons_req_i[c].addr.index] && idle_any;
        assign cons_rsp_o[c] = '{ready: ready_q[c], data: data_q[c]};
    end

    ////////////////////////////////////////
    // locks and assignments
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            assigned_q <= '0;
            lock_q     <= '0;
        end else begin
            // release on done, same edge the line is installed
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                if (fill_done_i[ch].done) begin
                    assigned_q[fill_done_i[ch].cons_id] <= 1'b0;
                    lock_q[fill_done_i[ch].index]       <= 1'b0;
                end
            end
            if (accept) begin
                assigned_q[gnt_id]       <= 1'b1;
                lock_q[gnt_addr.index]   <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // per consumer FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ready_q <= '0;
            for (int c = 0; c < NUM_CONSUMERS; c++) begin
                state_q[c] <= CONS_IDLE;
            end
        end else begin
            for (int c = 0; c < NUM_CONSUMERS; c++) begin
                case (state_q[c])
                    CONS_IDLE: begin
                        if (cons_req_i[c].valid) begin
                            ready_q[c] <= hit_i[c];
                            state_q[c] <= hit_i[c] ? CONS_RELAY : CONS_MISS;
                        end
                    end
                    // wait here until the filled line shows up as a hit
                    CONS_MISS: begin
                        if (!cons_req_i[c].valid) begin
                            state_q[c] <= CONS_IDLE;
                        end else if (hit_i[c]) begin
                            ready_q[c] <= 1'b1;
                            state_q[c] <= CONS_RELAY;
                        end
                    end
                    // hold ready until the consumer lets go
                    default: begin
                        if (!cons_req_i[c].valid) begin
                            ready_q[c] <= 1'b0;
                            state_q[c] <= CONS_IDLE;
                        end
                    end
                endcase
            end
        end
    end

    // latch the chunk on the hit that raises ready
    always_ff @(posedge clk) begin
        for (int c = 0; c < NUM_CONSUMERS; c++) begin
            if ((state_q[c] != CONS_RELAY) && cons_req_i[c].valid && hit_i[c]) begin
                data_q[c] <= rdata_i[c];
            end
        end
    end

endmodule

// ==== arbiter_cache.sv ====
`timescale 1ns/1ps

module arbiter_cache
    import arbiter_cache_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,
    input  cons_req_t [NUM_CONSUMERS-1:0]   cons_req_i,
    output cons_rsp_t [NUM_CONSUMERS-1:0]   cons_rsp_o,
    output mem_req_t  [NUM_CHANNELS-1:0]    mem_req_o,
    input  mem_rsp_t  [NUM_CHANNELS-1:0]    mem_rsp_i
);

    // lookup path
    addr_t        [NUM_CONSUMERS-1:0] lookup_addr;
    logic         [NUM_CONSUMERS-1:0] hit;
    chunk_t       [NUM_CONSUMERS-1:0] rdata;
    // miss arbitration
    logic         [NUM_CONSUMERS-1:0] eligible;
    logic         [NUM_CONSUMERS-1:0] grant;
    // fill channels
    logic         [NUM_CHANNELS-1:0]  chan_busy;
    fill_req_t    [NUM_CHANNELS-1:0]  start;
    fill_result_t [NUM_CHANNELS-1:0]  fill_result;

    cache_control u_control (
        .clk           (clk),
        .reset         (reset),
        .cons_req_i    (cons_req_i),
        .hit_i         (hit),
        .rdata_i       (rdata),
        .grant_i       (grant),
        .chan_busy_i   (chan_busy),
        .fill_done_i   (fill_result),
        .lookup_addr_o (lookup_addr),
        .eligible_o    (eligible),
        .start_o       (start),
        .cons_rsp_o    (cons_rsp_o)
    );

    line_store u_store (
        .clk           (clk),
        .reset         (reset),
        .lookup_addr_i (lookup_addr),
        .fill_i        (fill_result),
        .hit_o         (hit),
        .rdata_o       (rdata)
    );

    grant_picker u_picker (
        .clk        (clk),
        .reset      (reset),
        .eligible_i (eligible),
        .grant_o    (grant)
    );

    // one fill engine per memory channel
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
        fill_channel u_fill (
            .clk       (clk),
            .reset     (reset),
            .start_i   (start[ch]),
            .mem_rsp_i (mem_rsp_i[ch]),
            .mem_req_o (mem_req_o[ch]),
            .busy_o    (chan_busy[ch]),
            .result_o  (fill_result[ch])
        );
    end

endmodule

// ==== tb_arbiter_cache.sv ====
`timescale 1ns/1ps

module tb_arbiter_cache
    import arbiter_cache_pkg::*;
();

    localparam int NUM_STEPS   = 8;
    // each step gets a generous budget, plus reset and slack
    localparam int CYCLE_LIMIT = NUM_STEPS * 60 + 20;

    // one row of the stimulus table
    typedef struct packed {
        logic  [NUM_CONSUMERS-1:0] mask;
        addr_t [NUM_CONSUMERS-1:0] addr;
        logic  [NUM_CONSUMERS-1:0] exp_hit;
        logic                      both_chan;
    } step_t;

    logic                         clk = 1'b0;
    logic                         reset;
    cons_req_t [NUM_CONSUMERS-1:0] cons_req;
    cons_rsp_t [NUM_CONSUMERS-1:0] cons_rsp;
    mem_req_t  [NUM_CHANNELS-1:0]  mem_req;
    mem_rsp_t  [NUM_CHANNELS-1:0]  mem_rsp;

    step_t  steps     [NUM_STEPS];
    // answered chunks per channel, only the memory model writes it
    int     chan_reqs [NUM_CHANNELS];
    integer seed = 31125;
    int     data_errors  = 0;
    int     lat_errors   = 0;
    int     level_errors = 0;
    int     other_errors = 0;

    always #20 clk = ~clk;

    arbiter_cache UUT (
        .clk        (clk),
        .reset      (reset),
        .cons_req_i (cons_req),
        .cons_rsp_o (cons_rsp),
        .mem_req_o  (mem_req),
        .mem_rsp_i  (mem_rsp)
    );

    ////////////////////////////////////////
    // memory model and helpers
    ////////////////////////////////////////

    // memory content: low byte of address times 3, plus 1
    function automatic chunk_t mem_rule(input addr_t a);
        return chunk_t'(32'(a) * 3 + 1);
    endfunction

    function automatic logic [NUM_CONSUMERS-1:0] ready_vec();
        logic [NUM_CONSUMERS-1:0] v;
        for (int c = 0; c < NUM_CONSUMERS; c++) begin
            v[c] = cons_rsp[c].ready;
        end
        return v;
    endfunction

    // one memory per channel, random wait of 0 to 3 cycles then a ready pulse
    initial begin : memory_model
        logic armed     [NUM_CHANNELS];
        int   wait_left [NUM_CHANNELS];
        mem_rsp = '0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            armed[ch]     = 1'b0;
            wait_left[ch] = 0;
            chan_reqs[ch] = 0;
        end
        forever begin
            @(posedge clk);
            #2;
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                // pulse lasts a single cycle
                mem_rsp[ch].ready = 1'b0;
                if (reset) begin
                    armed[ch] = 1'b0;
                end else if (mem_req[ch].valid) begin
                    if (!armed[ch]) begin
                        armed[ch]     = 1'b1;
                        wait_left[ch] = int'($unsigned($random(seed)) % 4);
                    end
                    if (wait_left[ch] == 0) begin
                        mem_rsp[ch].ready = 1'b1;
                        mem_rsp[ch].data  = mem_rule(mem_req[ch].addr);
                        armed[ch]         = 1'b0;
                        chan_reqs[ch]     = chan_reqs[ch] + 1;
                    end else begin
                        wait_left[ch] = wait_left[ch] - 1;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_chunk(input string name, input chunk_t got, input chunk_t exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
            data_errors++;
        end
    endtask

    // got is high when ready came one edge after valid was sampled
    task automatic check_hit_latency(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            lat_errors++;
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error at %0t: %s got %b expected %b", $time, name, got, exp);
            level_errors++;
        end
    endtask

    ////////////////////////////////////////
    // stimulus table
    ////////////////////////////////////////

    // addresses packed with consumer 0 in the low byte
    task automatic set_step(input int row, input logic [NUM_CONSUMERS-1:0] mask,
                            input logic [NUM_CONSUMERS*ADDR_BITS-1:0] addrs,
                            input logic [NUM_CONSUMERS-1:0] exp_hit, input logic both_chan);
        steps[row].mask      = mask;
        steps[row].addr      = addrs;
        steps[row].exp_hit   = exp_hit;
        steps[row].both_chan = both_chan;
    endtask

    task automatic load_table();
        // cold read, then the other chunk of the same line
        set_step(0, 4'b0001, 32'h00_00_00_10, 4'b0000, 1'b0);
        set_step(1, 4'b0001, 32'h00_00_00_11, 4'b0001, 1'b0);
        // four misses on indexes 0 to 3, two channels in use
        set_step(2, 4'b1111, 32'h87_64_42_20, 4'b0000, 1'b1);
        // two consumers on one line, different offsets
        set_step(3, 4'b0110, 32'h00_a9_a8_00, 4'b0000, 1'b0);
        // index 8 with a new tag evicts 0x10, which then misses again
        set_step(4, 4'b1000, 32'h90_00_00_00, 4'b0000, 1'b0);
        set_step(5, 4'b1000, 32'h10_00_00_00, 4'b0000, 1'b0);
        set_step(6, 4'b0001, 32'h00_00_00_11, 4'b0001, 1'b0);
        // earlier fills are still resident
        set_step(7, 4'b0110, 32'h00_43_21_00, 4'b0110, 1'b0);
    endtask

    // entered and left 2 ns after a rising edge
    task automatic run_step(input int i);
        int    ready_at    [NUM_CONSUMERS];
        int    reqs_before [NUM_CHANNELS];
        int    cnt;
        step_t s;
        s   = steps[i];
        cnt = 0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            reqs_before[ch] = chan_reqs[ch];
        end
        for (int c = 0; c < NUM_CONSUMERS; c++) begin
            ready_at[c]       = 0;
            cons_req[c].addr  = s.addr[c];
            cons_req[c].valid = s.mask[c];
        end
        // count edges until each consumer sees ready
        while ((ready_vec() & s.mask) != s.mask) begin
            @(posedge clk);
            #1;
            cnt++;
            for (int c = 0; c < NUM_CONSUMERS; c++) begin
                if (s.mask[c] && cons_rsp[c].ready && (ready_at[c] == 0)) begin
                    ready_at[c] = cnt;
                end
            end
        end
        for (int c = 0; c < NUM_CONSUMERS; c++) begin
            if (s.mask[c]) begin
                check_chunk($sformatf("cons_rsp[%0d].data", c), cons_rsp[c].data,
                            mem_rule(s.addr[c]));
                check_hit_latency($sformatf("hit latency of consumer %0d", c),
                                  ready_at[c] == 1, s.exp_hit[c]);
            end
        end
        if (s.both_chan) begin
            for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
                if (chan_reqs[ch] == reqs_before[ch]) begin
                    $display("step %0d: memory channel %0d was never used for the fills", i, ch);
                    other_errors++;
                end
            end
        end
        // release and wait for every ready to drop
        #1;
        for (int c = 0; c < NUM_CONSUMERS; c++) begin
            cons_req[c].valid = 1'b0;
        end
        while (ready_vec() != '0) begin
            @(posedge clk);
            #1;
        end
        #1;
    endtask

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////

    initial begin
        reset    = 1'b1;
        cons_req = '0;
        load_table();
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        // nothing may be active straight out of reset
        for (int c = 0; c < NUM_CONSUMERS; c++) begin
            check_level($sformatf("cons_rsp[%0d].ready", c), cons_rsp[c].ready, 1'b0);
        end
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            check_level($sformatf("mem_req[%0d].valid", ch), mem_req[ch].valid, 1'b0);
        end
        @(posedge clk);
        #2;
        for (int i = 0; i < NUM_STEPS; i++) begin
            run_step(i);
        end
        $display("errors: %0d data, %0d latency, %0d level, %0d other",
                 data_errors, lat_errors, level_errors, other_errors);
        if (data_errors + lat_errors + level_errors + other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("test failed");
        $finish;
    end

endmodule

// ==== tb.f ====
arbiter_cache_pkg.sv
line_store.sv
grant_picker.sv
fill_channel.sv
cache_control.sv
arbiter_cache.sv
tb_arbiter_cache.sv

// ==== Makefile ====
# Verilator build and run of the arbiter cache testbench

VERILATOR ?= verilator
TOP       ?= tb_arbiter_cache
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= test passed
FAIL_MSG  ?= test failed

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
